// File: rtl/cd_rx_params.svh
// geometry and CRC constants for the serial bus receive path
`ifndef CD_RX_PARAMS_SVH
`define CD_RX_PARAMS_SVH

// index width, 64 blocks
`define CD_RX_I_WIDTH 6

// buffer address width, 2048 bytes
`define CD_RX_B_WIDTH 11

// block size width, 32-byte blocks
`define CD_RX_S_WIDTH (`CD_RX_B_WIDTH - `CD_RX_I_WIDTH)

// fragment count width, up to 8 blocks per frame
`define CD_RX_F_WIDTH (8 - `CD_RX_S_WIDTH)

// CRC-16/MODBUS, reflected
`define CD_RX_CRC_INIT 16'hffff
`define CD_RX_CRC_POLY 16'ha001

`endif

// File: rtl/cd_rx_pkg.sv
// shared byte and index-entry types of the receive path
`default_nettype none

`include "cd_rx_params.svh"

package cd_rx_pkg;

    // one data byte on the bus
    typedef logic [7:0] byte_t;

    // one committed frame in the index table
    typedef struct packed {
        logic                      err;  // crc, short or oversize error
        logic [`CD_RX_F_WIDTH-1:0] frag; // blocks used minus one
        logic [7:0]                len;  // frame length minus one, crc included
    } idx_entry_t;

endpackage

`default_nettype wire

// File: rtl/cd_rx_frame_if.sv
// byte write and commit path from the assembler to the receive RAM
`timescale 1ns/100ps
`default_nettype none

interface cd_rx_frame_if;

    cd_rx_pkg::byte_t wr_byte;
    logic [7:0]       wr_addr;     // byte offset within the frame
    logic             wr_en;       // one strobe per byte
    logic [7:0]       wr_len;      // frame length minus one
    logic             wr_err;
    logic             switch;      // commit pulse
    logic             switch_fail; // frame dropped

    modport asm (
        output wr_byte, wr_addr, wr_en, wr_len, wr_err, switch,
        input  switch_fail
    );

    modport ram (
        input  wr_byte, wr_addr, wr_en, wr_len, wr_err, switch,
        output switch_fail
    );

endinterface

`default_nettype wire

// File: rtl/cd_sdpram.sv
// simple dual-port synchronous RAM with one write and one read port
`timescale 1ns/100ps
`default_nettype none

module cd_sdpram #(
    parameter int  A_WIDTH = 8,
    parameter type data_t  = logic [7:0]
) (
    input  wire                clk,
    input  wire                wr_en,
    input  wire  [A_WIDTH-1:0] wr_addr,
    input  wire  data_t        wr_data,
    input  wire                rd_en,
    input  wire  [A_WIDTH-1:0] rd_addr,
    output data_t              rd_data
);

    data_t mem [2**A_WIDTH];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= mem[rd_addr]; // holds until the next read
        end
    end

endmodule

`default_nettype wire

// File: rtl/cd_rx_assembler.sv
// frame assembler that addresses bytes, checks the CRC-16 and requests the commit
`timescale 1ns/100ps
`default_nettype none

`include "cd_rx_params.svh"

module cd_rx_assembler (
    input  wire              clk,
    input  wire              reset_n,
    input  wire  cd_rx_pkg::byte_t rx_byte,
    input  wire              rx_valid,
    input  wire              rx_end,
    cd_rx_frame_if.asm       frame
);

    logic [8:0]  count;    // saturates at 256
    logic [15:0] crc;
    logic        oversize; // bytes dropped past offset 255

    // one byte through the reflected CRC-16
    function automatic logic [15:0] crc16_byte(
        input logic [15:0]      crc_in,
        input cd_rx_pkg::byte_t data
    );
        logic [15:0] c;
        c = crc_in ^ {8'h00, data};
        for (int i = 0; i < 8; i++) begin
            if (c[0]) begin
                c = (c >> 1) ^ `CD_RX_CRC_POLY;
            end else begin
                c = c >> 1;
            end
        end
        return c;
    endfunction

    // byte writes go out in the same cycle
    assign frame.wr_byte = rx_byte;
    assign frame.wr_addr = count[7:0];
    assign frame.wr_en   = rx_valid && !count[8];

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            count        <= '0;
            crc          <= `CD_RX_CRC_INIT;
            oversize     <= 1'b0;
            frame.switch <= 1'b0;
            frame.wr_len <= '0;
            frame.wr_err <= 1'b0;
        end else begin
            frame.switch <= 1'b0;

            if (rx_valid) begin
                if (count[8]) begin
                    oversize <= 1'b1; // byte 257 and later are not stored
                end else begin
                    count <= count + 9'd1;
                    crc   <= crc16_byte(crc, rx_byte);
                end
            end

            if (rx_end) begin
                frame.switch <= 1'b1;
                frame.wr_len <= 8'(count - 9'd1); // 256 bytes give 255
                frame.wr_err <= oversize || (count < 9'd3) || (crc != 16'h0000);
                count        <= '0;
                crc          <= `CD_RX_CRC_INIT;
                oversize     <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// File: rtl/cd_rx_ram.sv
// block-allocated receive frame buffer with an index table and read-side release
`timescale 1ns/100ps
`default_nettype none

`include "cd_rx_params.svh"

module cd_rx_ram (
    input  wire                         clk,
    input  wire                         reset_n,
    cd_rx_frame_if.ram                  frame,
    input  wire  [7:0]                  rd_addr,
    input  wire                         rd_en,
    input  wire                         rd_done,
    input  wire                         rd_done_all,
    output cd_rx_pkg::byte_t            rd_byte,
    output logic [7:0]                  rd_len,
    output logic                        rd_err,
    output logic                        unread,
    output logic [`CD_RX_I_WIDTH-1:0]   unread_len
);

    localparam int I_WIDTH = `CD_RX_I_WIDTH;
    localparam int B_WIDTH = `CD_RX_B_WIDTH;
    localparam int S_WIDTH = `CD_RX_S_WIDTH;
    localparam int F_WIDTH = `CD_RX_F_WIDTH;

    logic [I_WIDTH-1:0]    wr_sel;  // first block of the frame being written
    logic [I_WIDTH-1:0]    rd_sel;  // first block of the oldest frame
    logic [2**I_WIDTH-1:0] dirty;   // set on a frame's first block while unread
    logic [I_WIDTH-1:0]    wr_blk;

    logic                  wr_cancel;
    logic                  wr_en_d;
    logic                  switch_d;
    logic [F_WIDTH-1:0]    wr_frag;
    logic                  commit;
    logic                  release_frame;

    logic [B_WIDTH-1:0]    buf_wr_addr;
    logic [B_WIDTH-1:0]    buf_rd_addr;
    cd_rx_pkg::byte_t      buf_wr_data;
    logic [7:0]            wr_len_q;
    logic                  wr_err_q;

    cd_rx_pkg::idx_entry_t idx_wr;
    cd_rx_pkg::idx_entry_t idx_rd;

    assign wr_blk        = wr_sel + I_WIDTH'(frame.wr_addr[7:S_WIDTH]);
    assign buf_rd_addr   = {rd_sel, {S_WIDTH{1'b0}}} + B_WIDTH'(rd_addr);
    assign commit        = switch_d && !wr_cancel && !dirty[wr_sel]; // also guards empty frames
    assign release_frame = rd_done && dirty[rd_sel];

    always_comb begin
        idx_wr.err  = wr_err_q;
        idx_wr.frag = wr_frag;
        idx_wr.len  = wr_len_q;
    end

    assign rd_len = idx_rd.len;
    assign rd_err = idx_rd.err;

    cd_sdpram #(
        .A_WIDTH (B_WIDTH),
        .data_t  (cd_rx_pkg::byte_t)
    ) i_buf (
        .clk     (clk),
        .wr_en   (wr_en_d),
        .wr_addr (buf_wr_addr),
        .wr_data (buf_wr_data),
        .rd_en   (rd_en),
        .rd_addr (buf_rd_addr),
        .rd_data (rd_byte)
    );

    cd_sdpram #(
        .A_WIDTH (I_WIDTH),
        .data_t  (cd_rx_pkg::idx_entry_t)
    ) i_idx_table (
        .clk     (clk),
        .wr_en   (commit),
        .wr_addr (wr_sel),
        .wr_data (idx_wr),
        .rd_en   (dirty[rd_sel]),
        .rd_addr (rd_sel),
        .rd_data (idx_rd)
    );

    // byte and length capture
    always_ff @(posedge clk) begin
        buf_wr_addr <= {wr_sel, {S_WIDTH{1'b0}}} + B_WIDTH'(frame.wr_addr);
        buf_wr_data <= frame.wr_byte;
        if (frame.switch) begin
            wr_len_q <= frame.wr_len;
            wr_err_q <= frame.wr_err;
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            wr_sel            <= '0;
            rd_sel            <= '0;
            dirty             <= '0;
            wr_cancel         <= 1'b0;
            wr_en_d           <= 1'b0;
            switch_d          <= 1'b0;
            wr_frag           <= '0;
            unread            <= 1'b0;
            unread_len        <= '0;
            frame.switch_fail <= 1'b0;
        end else begin
            frame.switch_fail <= 1'b0;
            wr_en_d           <= 1'b0;
            switch_d          <= frame.switch;
            unread            <= dirty[rd_sel]; // one cycle behind the map

            if (switch_d) begin
                if (commit) begin
                    dirty[wr_sel] <= 1'b1;
                    wr_sel        <= wr_sel + I_WIDTH'(wr_frag) + 1'b1;
                end else begin
                    frame.switch_fail <= 1'b1;
                end
                wr_cancel <= 1'b0;
                wr_frag   <= '0;
            end

            if (frame.wr_en && !wr_cancel) begin
                if (dirty[wr_blk]) begin
                    wr_cancel <= 1'b1; // would overrun an unread frame
                end else begin
                    wr_en_d <= 1'b1;
                    wr_frag <= frame.wr_addr[7:S_WIDTH];
                end
            end

            if (release_frame) begin
                dirty[rd_sel] <= 1'b0;
                rd_sel        <= rd_sel + I_WIDTH'(idx_rd.frag) + 1'b1;
            end

            unread_len <= unread_len + I_WIDTH'(commit) - I_WIDTH'(release_frame);

            if (rd_done_all) begin
                frame.switch_fail <= 1'b0;
                wr_sel            <= '0;
                rd_sel            <= '0;
                dirty             <= '0;
                wr_cancel         <= 1'b0;
                switch_d          <= 1'b0;
                wr_frag           <= '0;
                unread_len        <= '0;
            end
        end
    end

endmodule

`default_nettype wire

// File: rtl/cd_rx_top.sv
// receive path top level with the assembler feeding the receive RAM
`timescale 1ns/100ps
`default_nettype none

`include "cd_rx_params.svh"

module cd_rx_top (
    input  wire                        clk,
    input  wire                        reset_n,

    input  wire  cd_rx_pkg::byte_t     rx_byte,
    input  wire                        rx_valid,
    input  wire                        rx_end,

    input  wire  [7:0]                 rd_addr,
    input  wire                        rd_en,
    input  wire                        rd_done,
    input  wire                        rd_done_all,
    output cd_rx_pkg::byte_t           rd_byte,
    output logic [7:0]                 rd_len,
    output logic                       rd_err,
    output logic                       unread,
    output logic [`CD_RX_I_WIDTH-1:0]  unread_len,
    output logic                       switch_fail
);

    cd_rx_frame_if frame_if ();

    cd_rx_assembler i_assembler (
        .clk      (clk),
        .reset_n  (reset_n),
        .rx_byte  (rx_byte),
        .rx_valid (rx_valid),
        .rx_end   (rx_end),
        .frame    (frame_if.asm)
    );

    cd_rx_ram i_ram (
        .clk         (clk),
        .reset_n     (reset_n),
        .frame       (frame_if.ram),
        .rd_addr     (rd_addr),
        .rd_en       (rd_en),
        .rd_done     (rd_done),
        .rd_done_all (rd_done_all),
        .rd_byte     (rd_byte),
        .rd_len      (rd_len),
        .rd_err      (rd_err),
        .unread      (unread),
        .unread_len  (unread_len)
    );

    assign switch_fail = frame_if.switch_fail; // dropped frame report

endmodule

`default_nettype wire

// File: verif/cd_rx_asserts.sv
// protocol checks on the receive RAM commit, drop and release paths
`timescale 1ns/100ps
`default_nettype none

`include "cd_rx_params.svh"

module cd_rx_asserts (
    input wire                      clk,
    input wire                      reset_n,
    input wire                      switch_fail,
    input wire                      rd_done,
    input wire                      rd_done_all,
    input wire [`CD_RX_I_WIDTH-1:0] unread_len
);

    int fail_count = 0;

    switch_fail_pulse: assert property (
        @(posedge clk) disable iff (!reset_n)
        switch_fail |=> !switch_fail
    ) else begin
        fail_count++;
        $error("switch_fail held for more than one cycle");
    end

    // only a release or a flush brings the count down
    unread_len_no_drop: assert property (
        @(posedge clk) disable iff (!reset_n)
        !rd_done && !rd_done_all |=> unread_len + 1'b1 != $past(unread_len)
    ) else begin
        fail_count++;
        $error("unread_len decremented without rd_done");
    end

    // a dropped frame leaves the count alone unless a release shares the edge
    fail_no_commit: assert property (
        @(posedge clk) disable iff (!reset_n)
        switch_fail && !$past(rd_done) |-> $stable(unread_len)
    ) else begin
        fail_count++;
        $error("unread_len changed on a dropped frame");
    end

endmodule

bind cd_rx_ram cd_rx_asserts i_asserts (
    .clk         (clk),
    .reset_n     (reset_n),
    .switch_fail (frame.switch_fail),
    .rd_done     (rd_done),
    .rd_done_all (rd_done_all),
    .unread_len  (unread_len)
);

`default_nettype wire

// File: verif/cd_rx_tb.sv
// random-frame testbench for the receive path with a reference model of the frame buffer
`timescale 1ns/100ps
`default_nettype none

`include "cd_rx_params.svh"

module cd_rx_tb;

    localparam int TIMEOUT = 200; // cycles allowed for unread to rise

    logic                         clk;
    logic                         reset_n;
    cd_rx_pkg::byte_t             rx_byte;
    logic                         rx_valid;
    logic                         rx_end;
    logic [7:0]                   rd_addr;
    logic                         rd_en;
    logic                         rd_done;
    logic                         rd_done_all;
    cd_rx_pkg::byte_t             rd_byte;
    logic [7:0]                   rd_len;
    logic                         rd_err;
    logic                         unread;
    logic [`CD_RX_I_WIDTH-1:0]    unread_len;
    logic                         switch_fail;

    int n_mismatch = 0;
    int n_timeout  = 0;
    logic dropped;

    // reference model of the buffer
    cd_rx_pkg::byte_t             frm[$];       // frame being sent
    cd_rx_pkg::byte_t             exp_bytes[$]; // stored bytes of all queued frames
    logic [7:0]                   exp_len[$];
    logic                         exp_err[$];
    logic [2**`CD_RX_I_WIDTH-1:0] m_dirty;
    logic [`CD_RX_I_WIDTH-1:0]    m_wr;
    logic [`CD_RX_I_WIDTH-1:0]    m_rd;

    cd_rx_top i_dut (
        .clk         (clk),
        .reset_n     (reset_n),
        .rx_byte     (rx_byte),
        .rx_valid    (rx_valid),
        .rx_end      (rx_end),
        .rd_addr     (rd_addr),
        .rd_en       (rd_en),
        .rd_done     (rd_done),
        .rd_done_all (rd_done_all),
        .rd_byte     (rd_byte),
        .rd_len      (rd_len),
        .rd_err      (rd_err),
        .unread      (unread),
        .unread_len  (unread_len),
        .switch_fail (switch_fail)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic check_value(input logic ok, input string what);
        assert (ok) else begin
            n_mismatch++;
            $display("mismatch at %0t: %s", $time, what);
        end
    endtask

    // CRC-16/MODBUS over the first n bytes, one bit at a time, lsb first
    function automatic logic [15:0] frame_crc(input int n);
        logic [15:0] c;
        logic        fb;
        c = `CD_RX_CRC_INIT;
        for (int i = 0; i < n; i++) begin
            for (int b = 0; b < 8; b++) begin
                fb = c[0] ^ frm[i][b];
                c  = c >> 1;
                if (fb) begin
                    c = c ^ `CD_RX_CRC_POLY;
                end
            end
        end
        return c;
    endfunction

    // kind 0 good, 1 corrupted, 2 short, 3 oversize
    task automatic build_frame(input int kind);
        int          n;
        logic [15:0] c;
        frm.delete();
        if (kind <= 1) begin
            n = 1 + $urandom % 254;
            repeat (n) frm.push_back(8'($urandom));
            c = frame_crc(n);
            frm.push_back(c[7:0]); // low byte first
            frm.push_back(c[15:8]);
            if (kind == 1) begin
                n = $urandom % frm.size();
                frm[n] = frm[n] ^ 8'(1 + $urandom % 255);
            end
        end else begin
            n = (kind == 2) ? 1 + $urandom % 2 : 257 + $urandom % 64;
            repeat (n) frm.push_back(8'($urandom));
        end
    endtask

    task automatic send_frame(output logic fail_seen);
        int                        n;
        int                        stored;
        logic                      cancel;
        logic                      done_seen;
        logic [`CD_RX_I_WIDTH-1:0] blk;
        logic [`CD_RX_I_WIDTH-1:0] len_before;
        n      = frm.size();
        stored = (n > 256) ? 256 : n;
        cancel = 1'b0;
        for (int a = 0; a < stored; a++) begin
            blk = m_wr + `CD_RX_I_WIDTH'(a >> `CD_RX_S_WIDTH);
            if (m_dirty[blk]) begin
                cancel = 1'b1; // write would hit an unread frame
            end
        end
        len_before = unread_len;
        for (int i = 0; i < n; i++) begin
            repeat ($urandom % 5) @(negedge clk);
            rx_byte  = frm[i];
            rx_valid = 1'b1;
            @(negedge clk);
            rx_valid = 1'b0;
        end
        rx_end = 1'b1;
        @(negedge clk);
        rx_end    = 1'b0;
        fail_seen = 1'b0;
        done_seen = 1'b0;
        for (int t = 0; t < 8 && !done_seen; t++) begin
            @(negedge clk);
            fail_seen = switch_fail;
            done_seen = switch_fail || (unread_len != len_before);
        end
        if (!done_seen) begin
            n_timeout++;
            $display("timeout: neither a commit nor switch_fail followed the frame end");
        end
        check_value(fail_seen == cancel,
                    $sformatf("switch_fail %b, model expects %b", fail_seen, cancel));
        if (!cancel) begin
            for (int i = 0; i < stored; i++) begin
                exp_bytes.push_back(frm[i]);
            end
            exp_len.push_back(8'(stored - 1));
            exp_err.push_back(n < 3 || n > 256 || frame_crc(n) != 16'h0000);
            m_dirty[m_wr] = 1'b1;
            m_wr = m_wr + `CD_RX_I_WIDTH'((stored - 1) >> `CD_RX_S_WIDTH) + 1'b1;
        end
        check_value(unread_len == `CD_RX_I_WIDTH'(exp_len.size()),
                    $sformatf("unread_len %0d after frame, model %0d",
                              unread_len, exp_len.size()));
        @(negedge clk); // unread lags the commit by a cycle
        check_value(unread == (exp_len.size() != 0), $sformatf("unread %b after frame", unread));
    endtask

    task automatic read_frame();
        int               n;
        int               t;
        cd_rx_pkg::byte_t exp_b;
        t = 0;
        while (!unread && t < TIMEOUT) begin
            @(negedge clk);
            t++;
        end
        if (!unread) begin
            n_timeout++;
            $display("timeout: unread stayed low while frames were pending");
        end
        n = exp_len[0] + 1;
        check_value(rd_len == exp_len[0],
                    $sformatf("rd_len %0d, expected %0d", rd_len, exp_len[0]));
        check_value(rd_err == exp_err[0],
                    $sformatf("rd_err %b, expected %b", rd_err, exp_err[0]));
        for (int i = 0; i < n; i++) begin
            rd_addr = 8'(i);
            rd_en   = 1'b1;
            @(negedge clk);
            exp_b = exp_bytes.pop_front();
            check_value(rd_byte == exp_b,
                        $sformatf("byte %0d read %h, expected %h", i, rd_byte, exp_b));
        end
        rd_en   = 1'b0;
        rd_done = 1'b1;
        @(negedge clk);
        rd_done = 1'b0;
        m_dirty[m_rd] = 1'b0;
        m_rd = m_rd + `CD_RX_I_WIDTH'((n - 1) >> `CD_RX_S_WIDTH) + 1'b1;
        void'(exp_len.pop_front());
        void'(exp_err.pop_front());
        check_value(unread_len == `CD_RX_I_WIDTH'(exp_len.size()),
                    $sformatf("unread_len %0d after release, model %0d",
                              unread_len, exp_len.size()));
        @(negedge clk); // unread lags the dirty map by a cycle
        check_value(unread == (exp_len.size() != 0), $sformatf("unread %b after release", unread));
    endtask

    initial begin
        void'($urandom(32'hbdc6));
        reset_n     = 1'b0;
        rx_byte     = '0;
        rx_valid    = 1'b0;
        rx_end      = 1'b0;
        rd_addr     = '0;
        rd_en       = 1'b0;
        rd_done     = 1'b0;
        rd_done_all = 1'b0;
        m_dirty     = '0;
        m_wr        = '0;
        m_rd        = '0;
        repeat (5) @(negedge clk);
        reset_n = 1'b1;
        @(negedge clk);

        // mixed frame kinds, drained after each burst
        repeat (12) begin
            repeat (1 + $urandom % 4) begin
                build_frame($urandom % 4);
                send_frame(dropped);
            end
            while (exp_len.size() != 0) read_frame();
        end

        // fill until the buffer drops a frame
        dropped = 1'b0;
        for (int k = 0; k < 64 && !dropped; k++) begin
            build_frame(0);
            send_frame(dropped);
        end
        check_value(dropped, "buffer never reported full");
        while (exp_len.size() != 0) read_frame();

        // flush with frames pending, then one frame after
        repeat (3) begin
            build_frame($urandom % 4);
            send_frame(dropped);
        end
        rd_done_all = 1'b1;
        @(negedge clk);
        rd_done_all = 1'b0;
        exp_bytes.delete();
        exp_len.delete();
        exp_err.delete();
        m_dirty = '0;
        m_wr    = '0;
        m_rd    = '0;
        check_value(unread_len == '0, $sformatf("unread_len %0d after flush", unread_len));
        @(negedge clk);
        check_value(!unread, "unread high after flush");
        build_frame(0);
        send_frame(dropped);
        while (exp_len.size() != 0) read_frame();

        repeat (4) @(negedge clk);
        $display("errors: %0d mismatches, %0d timeouts, %0d assertion failures",
                 n_mismatch, n_timeout, i_dut.i_ram.i_asserts.fail_count);
        if (n_mismatch == 0 && n_timeout == 0 && i_dut.i_ram.i_asserts.fail_count == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: src.f
+incdir+rtl
rtl/cd_rx_pkg.sv
rtl/cd_rx_frame_if.sv
rtl/cd_sdpram.sv
rtl/cd_rx_assembler.sv
rtl/cd_rx_ram.sv
rtl/cd_rx_top.sv
verif/cd_rx_asserts.sv
verif/cd_rx_tb.sv
